// ==== verilog/dm_pkg.sv ====
// ----------------------------------------------------------
// Shared constants and types for the debug module registers.
// Holds DMI widths, the opcode and error enums, the register
// map and the bit positions of every register field used.
// ----------------------------------------------------------
`default_nettype none

package dm_pkg;

  localparam int unsigned DmiAddrWidth = 7;
  localparam int unsigned DmiDataWidth = 32;
  localparam int unsigned HartSelWidth = 20;
  localparam int unsigned CmdErrWidth  = 3;
  localparam int unsigned DataCount    = 2;

  localparam logic [3:0] DbgVersion013 = 4'd2;

  typedef enum logic [1:0] {
    DtmNop   = 2'd0,
    DtmRead  = 2'd1,
    DtmWrite = 2'd2
  } dtm_op_e;

  typedef enum logic [1:0] {
    DtmSuccess = 2'd0,
    DtmBusy    = 2'd3
  } dtm_resp_e;

  typedef enum logic [CmdErrWidth-1:0] {
    CmdErrNone         = 3'd0,
    CmdErrBusy         = 3'd1,
    CmdErrNotSupported = 3'd2,
    CmdErrException    = 3'd3,
    CmdErrHalt         = 3'd4,
    CmdErrBus          = 3'd5,
    CmdErrOther        = 3'd7
  } cmderr_e;

  typedef enum logic [DmiAddrWidth-1:0] {
    Data0      = 7'h04,
    Data1      = 7'h05,
    DMControl  = 7'h10,
    DMStatus   = 7'h11,
    AbstractCS = 7'h16,
    Command    = 7'h17
  } dm_csr_e;

  // dmcontrol fields
  localparam int unsigned DmcHaltReq = 31, DmcResumeReq = 30, DmcAckHaveReset = 28;
  localparam int unsigned DmcHartSelLoHi = 25, DmcHartSelLoLo = 16;
  localparam int unsigned DmcHartSelHiHi = 15, DmcHartSelHiLo = 6;
  localparam int unsigned DmcNdmReset = 1, DmcDmActive = 0;

  // dmstatus fields
  localparam int unsigned DmsAllHaveReset = 19, DmsAnyHaveReset = 18;
  localparam int unsigned DmsAllResumeAck = 17, DmsAnyResumeAck = 16;
  localparam int unsigned DmsAllNonExist = 15, DmsAnyNonExist = 14;
  localparam int unsigned DmsAllUnavail = 13, DmsAnyUnavail = 12;
  localparam int unsigned DmsAllRunning = 11, DmsAnyRunning = 10;
  localparam int unsigned DmsAllHalted = 9, DmsAnyHalted = 8;
  localparam int unsigned DmsAuthenticated = 7, DmsVersionHi = 3, DmsVersionLo = 0;

  // abstractcs fields
  localparam int unsigned AcsProgBufHi = 28, AcsProgBufLo = 24, AcsBusy = 12;
  localparam int unsigned AcsCmdErrHi = 10, AcsCmdErrLo = 8;
  localparam int unsigned AcsDataCountHi = 3, AcsDataCountLo = 0;

endpackage

`default_nettype wire

// ==== verilog/dm_csr_if.sv ====
// ----------------------------------------------------------
// One decoded register access, from the DMI decoder to the
// register block that owns the address. The block answers
// in the same cycle with read data and a refusal flag.
// ----------------------------------------------------------
`default_nettype none

interface dm_csr_if
  import dm_pkg::*;
();

  logic                    req;
  logic                    write;
  dm_csr_e                 addr;
  logic [DmiDataWidth-1:0] wdata;
  logic [DmiDataWidth-1:0] rdata;
  logic                    busy_err;

  modport decoder (output req, write, addr, wdata, input rdata, busy_err);
  modport regs    (input req, write, addr, wdata, output rdata, busy_err);

endinterface

`default_nettype wire

// ==== verilog/dm_csr_access.sv ====
// ----------------------------------------------------------
// DMI request decoder. Accepts a request when the response
// queue has room, strobes the owning register block and
// forms the response entry pushed in the same cycle.
// ----------------------------------------------------------
`default_nettype none

module dm_csr_access
  import dm_pkg::*;
(
  input  logic                    dmi_req_valid_i,
  input  dtm_op_e                 dmi_req_op_i,
  input  logic [DmiAddrWidth-1:0] dmi_req_addr_i,
  input  logic [DmiDataWidth-1:0] dmi_req_data_i,
  input  logic                    queue_full_i,
  output logic                    dmi_req_ready_o,
  output logic                    push_o,
  output dtm_resp_e               push_resp_o,
  output logic [DmiDataWidth-1:0] push_data_o,
  dm_csr_if.decoder               hart_bus,
  dm_csr_if.decoder               abs_bus
);

  logic    accept;
  logic    is_access;
  logic    is_write;
  dm_csr_e csr_addr;

  assign dmi_req_ready_o = ~queue_full_i;
  assign accept          = dmi_req_valid_i & dmi_req_ready_o;
  assign push_o          = accept;
  assign is_write        = (dmi_req_op_i == DtmWrite);
  assign is_access       = accept & ((dmi_req_op_i == DtmRead) | is_write);
  assign csr_addr        = dm_csr_e'(dmi_req_addr_i);

  assign hart_bus.write = is_write;
  assign hart_bus.addr  = csr_addr;
  assign hart_bus.wdata = dmi_req_data_i;
  assign abs_bus.write  = is_write;
  assign abs_bus.addr   = csr_addr;
  assign abs_bus.wdata  = dmi_req_data_i;

  always_comb begin
    hart_bus.req = 1'b0;
    abs_bus.req  = 1'b0;
    push_resp_o  = DtmSuccess;
    push_data_o  = '0;
    case (csr_addr)
      DMControl, DMStatus: hart_bus.req = is_access;
      Data0, Data1, AbstractCS, Command: abs_bus.req = is_access;
      default: ;
    endcase
    // writes answer with zero data
    if (hart_bus.req) begin
      if (hart_bus.busy_err) begin
        push_resp_o = DtmBusy;
      end else if (!is_write) begin
        push_data_o = hart_bus.rdata;
      end
    end
    if (abs_bus.req) begin
      if (abs_bus.busy_err) begin
        push_resp_o = DtmBusy;
      end else if (!is_write) begin
        push_data_o = abs_bus.rdata;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dm_hart_ctrl.sv ====
// ----------------------------------------------------------
// Hart control block. Owns dmcontrol and the per-hart
// havereset flags, builds dmstatus for the selected hart and
// drives the one-hot halt and resume requests.
// ----------------------------------------------------------
`default_nettype none

module dm_hart_ctrl
  import dm_pkg::*;
#(
  parameter int unsigned NrHarts = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  dm_csr_if.regs                  bus,
  input  logic [NrHarts-1:0]      halted_i,
  input  logic [NrHarts-1:0]      unavailable_i,
  input  logic [NrHarts-1:0]      resumeack_i,
  output logic [HartSelWidth-1:0] hartsel_o,
  output logic [NrHarts-1:0]      haltreq_o,
  output logic [NrHarts-1:0]      resumereq_o,
  output logic                    clear_resumeack_o,
  output logic                    ndmreset_o,
  output logic                    dmactive_o
);

  localparam int unsigned SelW = (NrHarts > 1) ? $clog2(NrHarts) : 1;

  logic                    haltreq_q, resumereq_q, ndmreset_q, dmactive_q;
  logic                    resumereq_d, dmactive_d, dmc_write;
  logic [HartSelWidth-1:0] hartsel_q;
  logic [NrHarts-1:0]      havereset_q, havereset_d;
  logic [SelW-1:0]         sel_idx;
  logic                    sel_exists;
  logic [DmiDataWidth-1:0] dmcontrol, dmstatus;

  // state of the selected hart, zero when it does not exist
  function automatic logic pick(input logic [NrHarts-1:0] vec);
    return sel_exists & vec[sel_idx];
  endfunction

  assign sel_idx    = hartsel_q[SelW-1:0];
  assign sel_exists = (hartsel_q < HartSelWidth'(NrHarts));
  assign dmc_write  = bus.req & bus.write & (bus.addr == DMControl);
  assign dmactive_d = dmc_write ? bus.wdata[DmcDmActive] : dmactive_q;

  // resumereq drops once the selected hart acknowledges
  assign resumereq_d = (dmc_write ? bus.wdata[DmcResumeReq] : resumereq_q) &
                       ~(resumereq_q & pick(resumeack_i));
  assign clear_resumeack_o = dmc_write & bus.wdata[DmcResumeReq] & ~resumereq_q;

  always_comb begin
    havereset_d = havereset_q;
    if (dmc_write && bus.wdata[DmcAckHaveReset] && sel_exists) begin
      havereset_d[sel_idx] = 1'b0;
    end
    if (ndmreset_q) begin
      havereset_d = '1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      haltreq_q   <= 1'b0;
      resumereq_q <= 1'b0;
      hartsel_q   <= '0;
      ndmreset_q  <= 1'b0;
      dmactive_q  <= 1'b0;
      havereset_q <= '1;
    end else begin
      havereset_q <= havereset_d;
      dmactive_q  <= dmactive_d;
      if (!dmactive_d) begin
        haltreq_q   <= 1'b0;
        resumereq_q <= 1'b0;
        hartsel_q   <= '0;
        ndmreset_q  <= 1'b0;
      end else begin
        resumereq_q <= resumereq_d;
        if (dmc_write) begin
          haltreq_q  <= bus.wdata[DmcHaltReq];
          ndmreset_q <= bus.wdata[DmcNdmReset];
          hartsel_q  <= {bus.wdata[DmcHartSelHiHi:DmcHartSelHiLo],
                         bus.wdata[DmcHartSelLoHi:DmcHartSelLoLo]};
        end
      end
    end
  end

  // ----------------------------------------------------------
  // read-back and hart outputs
  // ----------------------------------------------------------
  always_comb begin
    dmcontrol = '0;
    dmcontrol[DmcHaltReq]                     = haltreq_q;
    dmcontrol[DmcResumeReq]                   = resumereq_q;
    dmcontrol[DmcHartSelLoHi:DmcHartSelLoLo] = hartsel_q[9:0];
    dmcontrol[DmcHartSelHiHi:DmcHartSelHiLo] = hartsel_q[19:10];
    dmcontrol[DmcNdmReset]                    = ndmreset_q;
    dmcontrol[DmcDmActive]                    = dmactive_q;

    dmstatus = '0;
    dmstatus[DmsAnyHaveReset]  = pick(havereset_q);
    dmstatus[DmsAnyResumeAck]  = pick(resumeack_i);
    dmstatus[DmsAnyNonExist]   = ~sel_exists;
    dmstatus[DmsAnyUnavail]    = pick(unavailable_i);
    dmstatus[DmsAnyRunning]    = pick(~halted_i & ~unavailable_i);
    dmstatus[DmsAnyHalted]     = pick(halted_i & ~unavailable_i);
    // a single hart is selected, so all equals any
    dmstatus[DmsAllHaveReset]  = dmstatus[DmsAnyHaveReset];
    dmstatus[DmsAllResumeAck]  = dmstatus[DmsAnyResumeAck];
    dmstatus[DmsAllNonExist]   = dmstatus[DmsAnyNonExist];
    dmstatus[DmsAllUnavail]    = dmstatus[DmsAnyUnavail];
    dmstatus[DmsAllRunning]    = dmstatus[DmsAnyRunning];
    dmstatus[DmsAllHalted]     = dmstatus[DmsAnyHalted];
    dmstatus[DmsAuthenticated] = 1'b1;
    dmstatus[DmsVersionHi:DmsVersionLo] = DbgVersion013;

    haltreq_o   = '0;
    resumereq_o = '0;
    if (sel_exists) begin
      haltreq_o[sel_idx]   = haltreq_q;
      resumereq_o[sel_idx] = resumereq_q;
    end
  end

  assign bus.rdata    = (bus.addr == DMControl) ? dmcontrol :
                        (bus.addr == DMStatus)  ? dmstatus  : '0;
  assign bus.busy_err = 1'b0;
  assign hartsel_o    = hartsel_q;
  assign ndmreset_o   = ndmreset_q;
  assign dmactive_o   = dmactive_q;

endmodule

`default_nettype wire

// ==== verilog/dm_abstract_regs.sv ====
// ----------------------------------------------------------
// Abstract command registers: command, cmderr and the data
// words. Accesses during a running command are refused and
// latch a busy error until the debugger clears it.
// ----------------------------------------------------------
`default_nettype none

module dm_abstract_regs
  import dm_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  dm_csr_if.regs                                  bus,
  input  logic                                    dmactive_i,
  input  logic                                    cmdbusy_i,
  input  logic                                    cmderror_valid_i,
  input  cmderr_e                                 cmderror_i,
  input  logic [DataCount-1:0][DmiDataWidth-1:0]  data_i,
  input  logic                                    data_valid_i,
  output logic                                    cmd_valid_o,
  output logic [DmiDataWidth-1:0]                 cmd_o,
  output logic [DataCount-1:0][DmiDataWidth-1:0]  data_o
);

  logic                                   wr;
  cmderr_e                                cmderr_q, cmderr_d;
  logic                                   cmd_valid_q;
  logic [DmiDataWidth-1:0]                command_q;
  logic [DataCount-1:0][DmiDataWidth-1:0] data_q;
  logic [DmiDataWidth-1:0]                abstractcs;

  assign bus.busy_err = bus.req & cmdbusy_i;
  assign wr           = bus.req & bus.write & ~cmdbusy_i;

  always_comb begin
    cmderr_d = cmderr_q;
    if (bus.busy_err && cmderr_q == CmdErrNone) begin
      cmderr_d = CmdErrBusy;
    end else if (wr && bus.addr == AbstractCS) begin
      // write one to clear
      cmderr_d = cmderr_e'(cmderr_q & ~bus.wdata[AcsCmdErrHi:AcsCmdErrLo]);
    end
    // the hart's report wins over the bus
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmderr_q    <= CmdErrNone;
      cmd_valid_q <= 1'b0;
    end else if (!dmactive_i) begin
      cmderr_q    <= CmdErrNone;
      cmd_valid_q <= 1'b0;
    end else begin
      cmderr_q    <= cmderr_d;
      cmd_valid_q <= wr & (bus.addr == Command);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!dmactive_i) begin
      command_q <= '0;
      data_q    <= '0;
    end else begin
      if (wr && bus.addr == Command) begin
        command_q <= bus.wdata;
      end
      if (data_valid_i) begin
        data_q <= data_i;
      end else if (wr && bus.addr == Data0) begin
        data_q[0] <= bus.wdata;
      end else if (wr && bus.addr == Data1) begin
        data_q[1] <= bus.wdata;
      end
    end
  end

  always_comb begin
    abstractcs = '0;
    abstractcs[AcsProgBufHi:AcsProgBufLo]     = '0;
    abstractcs[AcsBusy]                       = cmdbusy_i;
    abstractcs[AcsCmdErrHi:AcsCmdErrLo]       = cmderr_q;
    abstractcs[AcsDataCountHi:AcsDataCountLo] = 4'(DataCount);
  end

  // command reads as zero
  assign bus.rdata   = (bus.addr == Data0)      ? data_q[0]  :
                       (bus.addr == Data1)      ? data_q[1]  :
                       (bus.addr == AbstractCS) ? abstractcs : '0;
  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign data_o      = data_q;

endmodule

`default_nettype wire

// ==== verilog/dm_resp_fifo.sv ====
// ----------------------------------------------------------
// Two-entry DMI response queue. Push and pop may happen in
// the same cycle; flush empties it at the next clock edge.
// ----------------------------------------------------------
`default_nettype none

module dm_resp_fifo
  import dm_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  logic                    push_i,
  input  dtm_resp_e               push_resp_i,
  input  logic [DmiDataWidth-1:0] push_data_i,
  input  logic                    pop_i,
  output logic                    full_o,
  output logic                    empty_o,
  output dtm_resp_e               resp_o,
  output logic [DmiDataWidth-1:0] data_o
);

  dtm_resp_e               resp_mem [2];
  logic [DmiDataWidth-1:0] data_mem [2];
  logic                    rd_ptr_q, wr_ptr_q;
  logic [1:0]              count_q;
  logic                    do_push, do_pop;

  assign full_o  = (count_q == 2'd2);
  assign empty_o = (count_q == 2'd0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else if (flush_i) begin
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (do_push) wr_ptr_q <= ~wr_ptr_q;
      if (do_pop) rd_ptr_q <= ~rd_ptr_q;
      count_q <= count_q + 2'(do_push) - 2'(do_pop);
    end
  end

  // entry storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      resp_mem[wr_ptr_q] <= push_resp_i;
      data_mem[wr_ptr_q] <= push_data_i;
    end
  end

  assign resp_o = resp_mem[rd_ptr_q];
  assign data_o = data_mem[rd_ptr_q];

endmodule

`default_nettype wire

// ==== verilog/dm_csrs_top.sv ====
// ----------------------------------------------------------
// Debug module register file top level. Takes DMI requests,
// answers through a response queue and drives the hart and
// abstract command signals of the debug module.
// ----------------------------------------------------------
`default_nettype none

module dm_csrs_top
  import dm_pkg::*;
#(
  parameter int unsigned NrHarts = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   dmi_rst_ni,
  input  logic                                   dmi_req_valid_i,
  output logic                                   dmi_req_ready_o,
  input  dtm_op_e                                dmi_req_op_i,
  input  logic [DmiAddrWidth-1:0]                dmi_req_addr_i,
  input  logic [DmiDataWidth-1:0]                dmi_req_data_i,
  output logic                                   dmi_resp_valid_o,
  input  logic                                   dmi_resp_ready_i,
  output dtm_resp_e                              dmi_resp_resp_o,
  output logic [DmiDataWidth-1:0]                dmi_resp_data_o,
  output logic                                   ndmreset_o,
  output logic                                   dmactive_o,
  output logic [HartSelWidth-1:0]                hartsel_o,
  output logic [NrHarts-1:0]                     haltreq_o,
  output logic [NrHarts-1:0]                     resumereq_o,
  output logic                                   clear_resumeack_o,
  input  logic [NrHarts-1:0]                     halted_i,
  input  logic [NrHarts-1:0]                     unavailable_i,
  input  logic [NrHarts-1:0]                     resumeack_i,
  output logic                                   cmd_valid_o,
  output logic [DmiDataWidth-1:0]                cmd_o,
  input  logic                                   cmderror_valid_i,
  input  cmderr_e                                cmderror_i,
  input  logic                                   cmdbusy_i,
  output logic [DataCount-1:0][DmiDataWidth-1:0] data_o,
  input  logic [DataCount-1:0][DmiDataWidth-1:0] data_i,
  input  logic                                   data_valid_i
);

  logic                    queue_full, queue_empty, push;
  dtm_resp_e               push_resp;
  logic [DmiDataWidth-1:0] push_data;

  dm_csr_if hart_bus ();
  dm_csr_if abs_bus ();

  assign dmi_resp_valid_o = ~queue_empty;

  dm_csr_access u_access (
    .dmi_req_valid_i, .dmi_req_op_i, .dmi_req_addr_i, .dmi_req_data_i,
    .queue_full_i (queue_full),
    .dmi_req_ready_o,
    .push_o       (push),
    .push_resp_o  (push_resp),
    .push_data_o  (push_data),
    .hart_bus     (hart_bus.decoder),
    .abs_bus      (abs_bus.decoder)
  );

  dm_hart_ctrl #(.NrHarts(NrHarts)) u_hart_ctrl (
    .clk_i, .rst_ni,
    .bus (hart_bus.regs),
    .halted_i, .unavailable_i, .resumeack_i,
    .hartsel_o, .haltreq_o, .resumereq_o, .clear_resumeack_o,
    .ndmreset_o, .dmactive_o
  );

  dm_abstract_regs u_abstract_regs (
    .clk_i, .rst_ni,
    .bus        (abs_bus.regs),
    .dmactive_i (dmactive_o),
    .cmdbusy_i, .cmderror_valid_i, .cmderror_i, .data_i, .data_valid_i,
    .cmd_valid_o, .cmd_o, .data_o
  );

  // a DMI reset drops all pending responses
  dm_resp_fifo u_resp_fifo (
    .clk_i, .rst_ni,
    .flush_i     (~dmi_rst_ni),
    .push_i      (push),
    .push_resp_i (push_resp),
    .push_data_i (push_data),
    .pop_i       (dmi_resp_ready_i & dmi_resp_valid_o),
    .full_o      (queue_full),
    .empty_o     (queue_empty),
    .resp_o      (dmi_resp_resp_o),
    .data_o      (dmi_resp_data_o)
  );

endmodule

`default_nettype wire

// ==== verif/tb_dm_csrs.sv ====
// ----------------------------------------------------------
// Testbench for the debug module register file. Each record
// of the stimulus file is one DMI request or hart event with
// its expected results. Inputs change on the falling edge and
// outputs are sampled there too, while they are stable.
// ----------------------------------------------------------
`default_nettype none

module tb_dm_csrs
  import dm_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NrHarts  = 4;
  localparam int unsigned Fields   = 12;
  localparam int unsigned MaxRecs  = 64;
  localparam int unsigned BurstLen = 8;
  // opcodes above the DMI ones are testbench events
  localparam int unsigned OpLoad    = 4;
  localparam int unsigned OpHartErr = 5;
  localparam int unsigned OpBurst   = 6;
  localparam int unsigned OpFlush   = 7;

  logic                                   clk_i = 1'b0;
  logic                                   rst_ni, dmi_rst_ni;
  logic                                   dmi_req_valid_i, dmi_req_ready_o;
  dtm_op_e                                dmi_req_op_i;
  logic [DmiAddrWidth-1:0]                dmi_req_addr_i;
  logic [DmiDataWidth-1:0]                dmi_req_data_i;
  logic                                   dmi_resp_valid_o, dmi_resp_ready_i;
  dtm_resp_e                              dmi_resp_resp_o;
  logic [DmiDataWidth-1:0]                dmi_resp_data_o;
  logic                                   ndmreset_o, dmactive_o, clear_resumeack_o;
  logic [HartSelWidth-1:0]                hartsel_o;
  logic [NrHarts-1:0]                     haltreq_o, resumereq_o;
  logic [NrHarts-1:0]                     halted_i, unavailable_i, resumeack_i;
  logic                                   cmd_valid_o, cmderror_valid_i, cmdbusy_i;
  logic [DmiDataWidth-1:0]                cmd_o;
  cmderr_e                                cmderror_i;
  logic [DataCount-1:0][DmiDataWidth-1:0] data_o, data_i;
  logic                                   data_valid_i;

  logic [31:0]  stim_mem [MaxRecs*Fields];
  int unsigned  num_rec;
  int           errors, tests, test_errs;
  logic [31:0]  cur_id;
  logic [15:0]  lfsr;
  // clear_resumeack_o in the cycle the last request was taken
  logic         clear_seen;
  // resumereq as last written through dmcontrol
  logic         resume_pending;

  dm_csrs_top #(.NrHarts(NrHarts)) u_dut (.*);

  always #2 clk_i = ~clk_i;

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
    errors++;
    test_errs++;
  endtask

  task automatic note_failure(input string msg);
    $display("t=%0t %s", $time, msg);
    errors++;
    test_errs++;
  endtask

  task automatic finish_test(input logic [31:0] id);
    $display("test %0d finished with %0d errors", id, test_errs);
    tests++;
    test_errs = 0;
  endtask

  // holds the request until the decoder takes it
  task automatic send_request(input dtm_op_e op, input logic [6:0] addr,
                              input logic [31:0] data);
    logic taken;
    dmi_req_valid_i = 1'b1;
    dmi_req_op_i    = op;
    dmi_req_addr_i  = addr;
    dmi_req_data_i  = data;
    taken           = 1'b0;
    while (!taken) begin
      // the request path is combinational, let it settle
      #1;
      taken      = dmi_req_ready_o;
      clear_seen = clear_resumeack_o;
      @(negedge clk_i);
    end
    dmi_req_valid_i = 1'b0;
  endtask

  // hart-side outputs after a dmcontrol write, from the field layout
  task automatic check_hart_outputs(input logic [31:0] wdata);
    logic               act;
    logic [19:0]        sel;
    logic [NrHarts-1:0] exp_resume;
    act = wdata[0];
    sel = act ? {wdata[15:6], wdata[25:16]} : 20'h0;
    if (dmactive_o !== act)
      report_mismatch("dmactive_o", 32'(dmactive_o), 32'(act));
    if (ndmreset_o !== (act & wdata[1]))
      report_mismatch("ndmreset_o", 32'(ndmreset_o), 32'(act & wdata[1]));
    if (hartsel_o !== sel)
      report_mismatch("hartsel_o", 32'(hartsel_o), 32'(sel));
    exp_resume = '0;
    if (act && wdata[30] && sel < NrHarts)
      exp_resume[sel] = 1'b1;
    if (resumereq_o !== exp_resume)
      report_mismatch("resumereq_o", 32'(resumereq_o), 32'(exp_resume));
  endtask

  // reads alternate between Data0 and Data1 under random back-pressure
  task automatic read_burst(input logic [6:0] addr, input logic [31:0] even_val,
                            input logic [31:0] odd_val);
    int          got;
    logic [31:0] exp;
    got = 0;
    fork
      begin
        for (int i = 0; i < BurstLen; i++) begin
          send_request(DtmRead, addr + 7'(i % 2), 32'h0);
        end
      end
      begin
        while (got < BurstLen) begin
          lfsr = lfsr_step(lfsr);
          dmi_resp_ready_i = lfsr[0];
          if (dmi_resp_ready_i && dmi_resp_valid_o) begin
            exp = (got % 2 == 0) ? even_val : odd_val;
            if (dmi_resp_data_o !== exp)
              report_mismatch("dmi_resp_data_o", dmi_resp_data_o, exp);
            got++;
          end
          @(negedge clk_i);
        end
      end
    join
    dmi_resp_ready_i = 1'b1;
  endtask

  task automatic flush_queue(input logic [6:0] addr);
    dmi_resp_ready_i = 1'b0;
    send_request(DtmRead, addr, 32'h0);
    send_request(DtmRead, addr, 32'h0);
    if (dmi_req_ready_o !== 1'b0)
      note_failure("request ready stayed high with two unpopped responses");
    dmi_rst_ni = 1'b0;
    @(negedge clk_i);
    dmi_rst_ni = 1'b1;
    if (dmi_resp_valid_o !== 1'b0 || dmi_req_ready_o !== 1'b1)
      note_failure("response queue was not emptied by the DMI reset");
    dmi_resp_ready_i = 1'b1;
  endtask

  task automatic apply_record(input int unsigned r);
    logic [31:0] f [Fields];
    logic        cmd_seen;
    logic        is_dmc_write;
    logic        exp_clear;
    for (int k = 0; k < Fields; k++) begin
      f[k] = stim_mem[r * Fields + k];
    end
    halted_i      = f[4][NrHarts-1:0];
    unavailable_i = f[5][NrHarts-1:0];
    resumeack_i   = f[6][NrHarts-1:0];
    cmdbusy_i     = f[7][0];
    case (f[1])
      OpLoad: begin
        data_valid_i = 1'b1;
        data_i[0]    = f[3];
        data_i[1]    = ~f[3];
        @(negedge clk_i);
        data_valid_i = 1'b0;
        if (data_o[0] !== f[9])
          report_mismatch("data_o[0]", data_o[0], f[9]);
        if (data_o[1] !== ~f[3])
          report_mismatch("data_o[1]", data_o[1], ~f[3]);
      end
      OpHartErr: begin
        cmderror_valid_i = 1'b1;
        cmderror_i       = cmderr_e'(f[3][2:0]);
        @(negedge clk_i);
        cmderror_valid_i = 1'b0;
      end
      OpBurst: read_burst(f[2][6:0], f[9], f[3]);
      OpFlush: flush_queue(f[2][6:0]);
      default: begin
        send_request(dtm_op_e'(f[1][1:0]), f[2][6:0], f[3]);
        cmd_seen = 1'b0;
        while (!dmi_resp_valid_o) begin
          cmd_seen |= cmd_valid_o;
          @(negedge clk_i);
        end
        cmd_seen |= cmd_valid_o;
        if (dmi_resp_resp_o !== f[8][1:0])
          report_mismatch("dmi_resp_resp_o", 32'(dmi_resp_resp_o), f[8]);
        if (dmi_resp_data_o !== f[9])
          report_mismatch("dmi_resp_data_o", dmi_resp_data_o, f[9]);
        if (haltreq_o !== f[10][NrHarts-1:0])
          report_mismatch("haltreq_o", 32'(haltreq_o), f[10]);
        if (cmd_seen !== f[11][0])
          report_mismatch("cmd_valid_o", 32'(cmd_seen), f[11]);
        if (f[11][0] && cmd_o !== f[3])
          report_mismatch("cmd_o", cmd_o, f[3]);
        // resumereq rising on a dmcontrol write asks the hart to clear resumeack
        is_dmc_write = (f[1][1:0] == DtmWrite) && (f[2][6:0] == DMControl);
        exp_clear    = is_dmc_write & f[3][0] & f[3][30] & ~resume_pending;
        if (clear_seen !== exp_clear)
          report_mismatch("clear_resumeack_o", 32'(clear_seen), 32'(exp_clear));
        if (is_dmc_write) begin
          check_hart_outputs(f[3]);
          resume_pending = f[3][0] & f[3][30];
        end
        // the response pops at this rising edge
        @(negedge clk_i);
      end
    endcase
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    rst_ni           = 1'b0;
    dmi_rst_ni       = 1'b1;
    dmi_req_valid_i  = 1'b0;
    dmi_req_op_i     = DtmNop;
    dmi_req_addr_i   = '0;
    dmi_req_data_i   = '0;
    dmi_resp_ready_i = 1'b1;
    halted_i         = '0;
    unavailable_i    = '0;
    resumeack_i      = '0;
    cmderror_valid_i = 1'b0;
    cmderror_i       = CmdErrNone;
    cmdbusy_i        = 1'b0;
    data_i           = '0;
    data_valid_i     = 1'b0;
    lfsr             = 16'd54909;
    errors           = 0;
    tests            = 0;
    test_errs        = 0;
    cur_id           = '0;
    clear_seen       = 1'b0;
    resume_pending   = 1'b0;
    for (int i = 0; i < MaxRecs * Fields; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("verif/dm_stim.txt", stim_mem);
    num_rec = 0;
    while (num_rec < MaxRecs && stim_mem[num_rec * Fields] != 0) begin
      num_rec++;
    end
    if (num_rec == 0)
      note_failure("no records found in the stimulus file");

    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    for (int unsigned r = 0; r < num_rec; r++) begin
      if (r > 0 && stim_mem[r * Fields] != cur_id) begin
        finish_test(cur_id);
      end
      cur_id = stim_mem[r * Fields];
      apply_record(r);
    end
    if (num_rec > 0) begin
      finish_test(cur_id);
    end

    $display("records %0d, tests %0d, errors %0d", num_rec, tests, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // budget of 200 cycles per record
  initial begin : watchdog
    int unsigned budget;
    wait (rst_ni === 1'b1);
    budget = num_rec * 200 + 16;
    repeat (budget) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", budget);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/dm_stim.txt ====
// id op addr wdata halted unavail resumeack cmdbusy exp_resp exp_data exp_haltreq exp_cmd
// op: 1 read, 2 write, 4 data load, 5 hart error, 6 back-pressure burst, 7 flush
1 2 10 FFFFFFFF 0 0 0 0 0 00000000 0 0
1 1 10 00000000 0 0 0 0 0 C3FFFFC3 0 0
1 2 10 00000000 0 0 0 0 0 00000000 0 0
1 1 10 00000000 0 0 0 0 0 00000000 0 0
2 2 10 00020001 4 0 0 0 0 00000000 0 0
2 1 11 00000000 4 0 0 0 0 000C0382 0 0
2 1 11 00000000 4 4 0 0 0 000C3082 0 0
2 1 11 00000000 0 0 0 0 0 000C0C82 0 0
2 2 10 80020001 0 0 0 0 0 00000000 4 0
2 2 10 80050001 0 0 0 0 0 00000000 0 0
2 1 11 00000000 0 0 0 0 0 0000C082 0 0
3 2 10 00010001 0 0 0 0 0 00000000 0 0
3 1 11 00000000 0 0 0 0 0 000C0C82 0 0
3 2 10 10010001 0 0 0 0 0 00000000 0 0
3 1 11 00000000 0 0 0 0 0 00000C82 0 0
3 2 10 00010003 0 0 0 0 0 00000000 0 0
3 2 10 00010001 0 0 0 0 0 00000000 0 0
3 1 11 00000000 0 0 0 0 0 000C0C82 0 0
4 2 17 00221008 0 0 0 0 0 00000000 0 1
4 1 16 00000000 0 0 0 0 0 00000002 0 0
4 2 17 00221008 0 0 0 1 3 00000000 0 0
4 1 16 00000000 0 0 0 0 0 00000102 0 0
4 2 16 00000700 0 0 0 0 0 00000000 0 0
4 1 16 00000000 0 0 0 0 0 00000002 0 0
4 1 17 00000000 0 0 0 0 0 00000000 0 0
5 2 04 DEADBEEF 0 0 0 0 0 00000000 0 0
5 2 05 12345678 0 0 0 0 0 00000000 0 0
5 1 04 00000000 0 0 0 0 0 DEADBEEF 0 0
5 1 05 00000000 0 0 0 0 0 12345678 0 0
5 4 00 A5A50F0F 0 0 0 0 0 A5A50F0F 0 0
5 1 04 00000000 0 0 0 0 0 A5A50F0F 0 0
5 1 05 00000000 0 0 0 0 0 5A5AF0F0 0 0
5 5 00 00000003 0 0 0 0 0 00000000 0 0
5 1 16 00000000 0 0 0 0 0 00000302 0 0
5 2 16 00000700 0 0 0 0 0 00000000 0 0
6 6 04 5A5AF0F0 0 0 0 0 0 A5A50F0F 0 0
6 7 04 00000000 0 0 0 0 0 00000000 0 0
6 1 04 00000000 0 0 0 0 0 A5A50F0F 0 0

// ==== filelist.f ====
verilog/dm_pkg.sv
verilog/dm_csr_if.sv
verilog/dm_csr_access.sv
verilog/dm_hart_ctrl.sv
verilog/dm_abstract_regs.sv
verilog/dm_resp_fifo.sv
verilog/dm_csrs_top.sv
verif/tb_dm_csrs.sv

// ==== Makefile ====
TOP = tb_dm_csrs

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f filelist.f --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
